// File: project.f
rvs_pkg.sv
rvs_decode.sv
rvs_regfile.sv
rvs_alu.sv
rvs_ctrl.sv
rvs_mem_if.sv
rvs_arbiter.sv
rvs_top.sv
tb_clock.sv
tb_rvs_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_rvs_top
FILELIST  = project.f
LOG       = sim.log
OBJDIR    = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		exit 1; \
	fi
	@grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb_rvs_top.sv
module tb_rvs_top;

   localparam int          CLK_PERIOD = 40;
   localparam logic [31:0] RESET_PC   = 32'h100;
   localparam logic [31:0] STORE_BASE = 32'h300;
   localparam logic [31:0] DATA_BASE  = 32'h200;

   logic              clk;
   logic              i_rst_n;
   logic [31:0]       i_mem_rdt;
   logic              i_mem_ack;
   rvs_pkg::bus_req_t mem_req;

   // Word memory, 1 KB
   logic [31:0]       mem [0:255];
   logic [31:0]       prog_q [$];
   rvs_pkg::bus_req_t ev_q [$];
   string             ev_name [$];
   logic [31:0]       ld_pc;
   int                ev_idx;
   int                rst_edges;
   int                delay;
   integer            seed;
   logic              busy;
   logic              tables_ready;
   logic              all_seen;
   rvs_pkg::bus_req_t held;
   string             cur_name;
   logic [31:0]       skipped;

   tb_clock #(
      .PERIOD (CLK_PERIOD)
   ) u_clock (
      .o_clk (clk)
   );

   rvs_top #(
      .RESET_PC (RESET_PC)
   ) DUT (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .o_mem     (mem_req),
      .i_mem_rdt (i_mem_rdt),
      .i_mem_ack (i_mem_ack)
   );

   function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, rvs_pkg::OPC_OP};
   endfunction

   function automatic logic [31:0] i_format(input logic [6:0] opc, input logic [4:0] rd,
                                            input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [11:0] imm);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] s_format(input logic [2:0] f3, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], rvs_pkg::OPC_STORE};
   endfunction

   function automatic logic [31:0] b_format(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvs_pkg::OPC_BRANCH};
   endfunction

   function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, rvs_pkg::OPC_LUI};
   endfunction

   function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, rvs_pkg::OPC_JAL};
   endfunction

   function automatic logic [7:0] word_index(input logic [31:0] adr);
      return adr[9:2];
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         report_failure($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic add_event(input string name, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we);
      rvs_pkg::bus_req_t ev;
      ev.adr = adr;
      ev.dat = dat;
      ev.sel = sel;
      ev.we  = we;
      ev.cyc = 1'b1;
      ev_q.push_back(ev);
      ev_name.push_back(name);
   endtask

   // Places an instruction and expects its fetch
   task automatic step(input string name, input logic [31:0] instr);
      prog_q.push_back(instr);
      add_event(name, ld_pc, 32'h0, 4'hf, 1'b0);
      ld_pc = ld_pc + 32'd4;
   endtask

   task automatic skip_slot(input logic [31:0] instr);
      prog_q.push_back(instr);
      ld_pc = ld_pc + 32'd4;
   endtask

   task automatic store_result(input string name, input logic [4:0] rs2,
                               input logic [11:0] off, input logic [31:0] exp);
      step(name, s_format(rvs_pkg::F3_SW, rs2, 5'd2, off));
      add_event(name, STORE_BASE + {20'h0, off}, exp, 4'hf, 1'b1);
   endtask

   task automatic byte_store(input string name, input logic [4:0] rs2, input logic [11:0] off,
                             input logic [31:0] exp, input logic [3:0] sel);
      step(name, s_format(rvs_pkg::F3_SB, rs2, 5'd2, off));
      add_event(name, (STORE_BASE + {20'h0, off}) & 32'hffff_fffc, exp, sel, 1'b1);
   endtask

   task automatic build_tables();
      ld_pc   = RESET_PC;
      skipped = s_format(rvs_pkg::F3_SW, 5'd1, 5'd2, 12'h0f0);
      step("lui x1", lui_word(5'd1, 20'habcde));
      step("addi base", i_format(rvs_pkg::OPC_OP_IMM, 5'd2, rvs_pkg::F3_ADD, 5'd0,
                                 STORE_BASE[11:0]));
      step("addi x3", i_format(rvs_pkg::OPC_OP_IMM, 5'd3, rvs_pkg::F3_ADD, 5'd0, 12'd45));
      step("addi neg", i_format(rvs_pkg::OPC_OP_IMM, 5'd4, rvs_pkg::F3_ADD, 5'd0, -12'd7));
      step("add", r_format(7'h0, 5'd4, 5'd3, rvs_pkg::F3_ADD, 5'd5));
      step("sub", r_format(rvs_pkg::F7_SUB, 5'd4, 5'd3, rvs_pkg::F3_ADD, 5'd6));
      step("and", r_format(7'h0, 5'd4, 5'd3, rvs_pkg::F3_AND, 5'd7));
      step("or", r_format(7'h0, 5'd3, 5'd1, rvs_pkg::F3_OR, 5'd8));
      step("xor", r_format(7'h0, 5'd4, 5'd1, rvs_pkg::F3_XOR, 5'd9));
      step("slt true", r_format(7'h0, 5'd3, 5'd4, rvs_pkg::F3_SLT, 5'd10));
      step("slt false", r_format(7'h0, 5'd4, 5'd3, rvs_pkg::F3_SLT, 5'd11));
      step("addi x0", i_format(rvs_pkg::OPC_OP_IMM, 5'd0, rvs_pkg::F3_ADD, 5'd0, 12'd123));
      // 45 and -7 as operands
      store_result("sw lui", 5'd1, 12'd0, 32'habcde000);
      store_result("sw add", 5'd5, 12'd4, 32'h0000_0026);
      store_result("sw sub", 5'd6, 12'd8, 32'h0000_0034);
      store_result("sw and", 5'd7, 12'd12, 32'h0000_0029);
      store_result("sw or", 5'd8, 12'd16, 32'habcd_e02d);
      store_result("sw xor", 5'd9, 12'd20, 32'h5432_1ff9);
      store_result("sw slt true", 5'd10, 12'd24, 32'h0000_0001);
      store_result("sw slt false", 5'd11, 12'd28, 32'h0000_0000);
      store_result("sw x0", 5'd0, 12'd32, 32'h0000_0000);
      // Loads from the data word 12f08c7e
      step("addi data", i_format(rvs_pkg::OPC_OP_IMM, 5'd12, rvs_pkg::F3_ADD, 5'd0,
                                 DATA_BASE[11:0]));
      step("lw", i_format(rvs_pkg::OPC_LOAD, 5'd13, rvs_pkg::F3_LW, 5'd12, 12'd0));
      add_event("lw", DATA_BASE, 32'h0, 4'hf, 1'b0);
      step("lb", i_format(rvs_pkg::OPC_LOAD, 5'd14, rvs_pkg::F3_LB, 5'd12, 12'd1));
      add_event("lb", DATA_BASE, 32'h0, 4'b0010, 1'b0);
      step("lbu", i_format(rvs_pkg::OPC_LOAD, 5'd15, rvs_pkg::F3_LBU, 5'd12, 12'd1));
      add_event("lbu", DATA_BASE, 32'h0, 4'b0010, 1'b0);
      store_result("sw lw", 5'd13, 12'd36, 32'h12f0_8c7e);
      store_result("sw lb", 5'd14, 12'd40, 32'hffff_ff8c);
      store_result("sw lbu", 5'd15, 12'd44, 32'h0000_008c);
      byte_store("sb lane0", 5'd3, 12'd48, 32'h2d2d_2d2d, 4'b0001);
      byte_store("sb lane1", 5'd4, 12'd49, 32'hf9f9_f9f9, 4'b0010);
      byte_store("sb lane2", 5'd5, 12'd50, 32'h2626_2626, 4'b0100);
      byte_store("sb lane3", 5'd6, 12'd51, 32'h3434_3434, 4'b1000);
      step("lw merged", i_format(rvs_pkg::OPC_LOAD, 5'd16, rvs_pkg::F3_LW, 5'd2, 12'd48));
      add_event("lw merged", STORE_BASE + 32'd48, 32'h0, 4'hf, 1'b0);
      store_result("sw merged", 5'd16, 12'd52, 32'h3426_f92d);
      // Branch targets land past the skipped slots
      step("beq not taken", b_format(rvs_pkg::F3_BEQ, 5'd3, 5'd5, 13'd8));
      step("beq taken", b_format(rvs_pkg::F3_BEQ, 5'd11, 5'd0, 13'd12));
      skip_slot(skipped);
      skip_slot(skipped);
      step("bne not taken", b_format(rvs_pkg::F3_BNE, 5'd3, 5'd3, 13'd8));
      step("bne taken", b_format(rvs_pkg::F3_BNE, 5'd3, 5'd4, 13'd12));
      skip_slot(skipped);
      skip_slot(skipped);
      step("jal link", jal_word(5'd18, 21'd12));
      skip_slot(skipped);
      skip_slot(skipped);
      store_result("sw link", 5'd18, 12'd56, 32'h0000_01ac);
      step("custom opcode", 32'h0000_000b);
      step("jal self", jal_word(5'd0, 21'd0));
      add_event("jal self loop", ld_pc - 32'd4, 32'h0, 4'hf, 1'b0);
   endtask

   task automatic match_event(input rvs_pkg::bus_req_t req);
      if (ev_idx >= ev_q.size()) begin
         report_failure("A bus request appeared after the last expected event");
      end else begin
         cur_name = ev_name[ev_idx];
         check($sformatf("%s adr", cur_name), ev_q[ev_idx].adr, req.adr);
         check($sformatf("%s we", cur_name), {31'h0, ev_q[ev_idx].we}, {31'h0, req.we});
         check($sformatf("%s sel", cur_name), {28'h0, ev_q[ev_idx].sel}, {28'h0, req.sel});
         if (ev_q[ev_idx].we) begin
            check($sformatf("%s dat", cur_name), ev_q[ev_idx].dat, req.dat);
         end
         ev_idx++;
         if (ev_idx == ev_q.size()) begin
            all_seen = 1'b1;
         end
      end
   endtask

   task automatic check_held(input string tag);
      check($sformatf("%s %s cyc", cur_name, tag), 32'h1, {31'h0, mem_req.cyc});
      check($sformatf("%s %s adr", cur_name, tag), held.adr, mem_req.adr);
      check($sformatf("%s %s dat", cur_name, tag), held.dat, mem_req.dat);
      check($sformatf("%s %s sel", cur_name, tag), {28'h0, held.sel}, {28'h0, mem_req.sel});
      check($sformatf("%s %s we", cur_name, tag), {31'h0, held.we}, {31'h0, mem_req.we});
   endtask

   task automatic write_lanes(input rvs_pkg::bus_req_t req);
      for (int b = 0; b < 4; b++) begin
         if (req.sel[b]) begin
            mem[word_index(req.adr)][8*b +: 8] = req.dat[8*b +: 8];
         end
      end
   endtask

   // Memory model, ack after 0 to 3 wait cycles
   initial begin
      i_mem_ack    = 1'b0;
      i_mem_rdt    = 32'h0;
      tables_ready = 1'b0;
      all_seen     = 1'b0;
      busy         = 1'b0;
      ev_idx       = 0;
      rst_edges    = 0;
      delay        = 0;
      seed         = 32'h05d3c636;
      for (int i = 0; i < 256; i++) begin
         mem[i] = 32'hc0de_0000 | (i << 2);
      end
      mem[word_index(DATA_BASE)] = 32'h12f0_8c7e;
      build_tables();
      for (int i = 0; i < prog_q.size(); i++) begin
         mem[word_index(RESET_PC + (i << 2))] = prog_q[i];
      end
      tables_ready = 1'b1;
      forever begin
         @(posedge clk);
         if (!i_rst_n) begin
            // The first edge may still show unreset state
            if (rst_edges > 0) begin
               check("reset adr", RESET_PC, mem_req.adr);
               check("reset cyc", 32'h0, {31'h0, mem_req.cyc});
            end
            rst_edges++;
         end else if (i_mem_ack) begin
            check_held("ack cycle");
            i_mem_ack <= 1'b0;
         end else if (mem_req.cyc) begin
            if (!busy) begin
               busy  = 1'b1;
               held  = mem_req;
               delay = $random(seed) & 3;
               match_event(held);
            end else begin
               check_held("wait");
            end
            if (delay == 0) begin
               i_mem_ack <= 1'b1;
               i_mem_rdt <= mem[word_index(held.adr)];
               if (held.we) begin
                  write_lanes(held);
               end
               busy = 1'b0;
            end else begin
               delay--;
            end
         end
      end
   end

   initial begin
      i_rst_n = 1'b0;
      repeat (8) @(posedge clk);
      i_rst_n <= 1'b1;
      wait (all_seen);
      $display("No errors");
      $finish;
   end

   initial begin
      wait (tables_ready);
      #(ev_q.size() * 10 * CLK_PERIOD);
      report_failure("Timeout: the bus events did not complete in time");
   end

endmodule

// File: tb_clock.sv
module tb_clock #(
   parameter int PERIOD = 40
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD / 2) o_clk = ~o_clk;
      end
   end

endmodule

// File: rvs_top.sv
module rvs_top #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic              clk,
   input  logic              i_rst_n,
   output rvs_pkg::bus_req_t o_mem,
   input  logic [31:0]       i_mem_rdt,
   input  logic              i_mem_ack
);

   rvs_pkg::bus_req_t ibus;
   rvs_pkg::bus_req_t dbus;
   rvs_pkg::dec_t     dec;
   rvs_pkg::alu_op_t  alu_op;
   logic              ibus_ack;
   logic              dbus_ack;
   logic [31:0]       rdt;
   logic [31:0]       alu_a;
   logic [31:0]       alu_b;
   logic [31:0]       alu_result;
   logic              alu_eq;
   logic              mem_start;
   logic              mem_done;
   logic [31:0]       mem_rd;
   logic              rf_wen;
   logic [4:0]        rf_waddr;
   logic [31:0]       rf_wdata;
   logic [4:0]        rf_raddr1;
   logic [4:0]        rf_raddr2;
   logic [31:0]       rf_rdata1;
   logic [31:0]       rf_rdata2;

   assign alu_op = dec.alu_op;

   rvs_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_ctrl (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .o_ibus       (ibus),
      .i_ibus_ack   (ibus_ack),
      .i_rdt        (rdt),
      .o_dec        (dec),
      .o_imm        (),
      .o_alu_a      (alu_a),
      .o_alu_b      (alu_b),
      .i_alu_result (alu_result),
      .i_alu_eq     (alu_eq),
      .o_mem_start  (mem_start),
      .i_mem_done   (mem_done),
      .i_mem_rd     (mem_rd),
      .o_rf_wen     (rf_wen),
      .o_rf_waddr   (rf_waddr),
      .o_rf_wdata   (rf_wdata),
      .o_rf_raddr1  (rf_raddr1),
      .o_rf_raddr2  (rf_raddr2),
      .i_rf_rdata1  (rf_rdata1),
      .i_rf_rdata2  (rf_rdata2)
   );

   rvs_regfile u_regfile (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_wen    (rf_wen),
      .i_waddr  (rf_waddr),
      .i_wdata  (rf_wdata),
      .i_raddr1 (rf_raddr1),
      .i_raddr2 (rf_raddr2),
      .o_rdata1 (rf_rdata1),
      .o_rdata2 (rf_rdata2)
   );

   rvs_alu u_alu (
      .i_op     (alu_op),
      .i_a      (alu_a),
      .i_b      (alu_b),
      .o_result (alu_result),
      .o_eq     (alu_eq)
   );

   // Store data comes straight from rs2
   rvs_mem_if u_mem_if (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_start    (mem_start),
      .i_dec      (dec),
      .i_adr      (alu_result),
      .i_wdata    (rf_rdata2),
      .o_dbus     (dbus),
      .i_dbus_ack (dbus_ack),
      .i_rdt      (rdt),
      .o_done     (mem_done),
      .o_rd       (mem_rd)
   );

   rvs_arbiter u_arbiter (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus     (ibus),
      .o_ibus_ack (ibus_ack),
      .i_dbus     (dbus),
      .o_dbus_ack (dbus_ack),
      .o_mem      (o_mem),
      .i_mem_ack  (i_mem_ack),
      .i_mem_rdt  (i_mem_rdt),
      .o_rdt      (rdt)
   );

endmodule

// File: rvs_arbiter.sv
module rvs_arbiter (
   input  logic              clk,
   input  logic              i_rst_n,
   input  rvs_pkg::bus_req_t i_ibus,
   output logic              o_ibus_ack,
   input  rvs_pkg::bus_req_t i_dbus,
   output logic              o_dbus_ack,
   output rvs_pkg::bus_req_t o_mem,
   input  logic              i_mem_ack,
   input  logic [31:0]       i_mem_rdt,
   output logic [31:0]       o_rdt
);

   logic gnt_q;
   logic hold_q;
   logic gnt_data;

   // Keep the previous owner while its transfer is still open
   assign gnt_data = hold_q ? gnt_q : i_dbus.cyc;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         gnt_q  <= 1'b0;
         hold_q <= 1'b0;
      end else begin
         gnt_q  <= gnt_data;
         hold_q <= o_mem.cyc & ~i_mem_ack;
      end
   end

   assign o_mem      = gnt_data ? i_dbus : i_ibus;
   assign o_ibus_ack = i_mem_ack & ~gnt_data;
   assign o_dbus_ack = i_mem_ack & gnt_data;
   assign o_rdt      = i_mem_rdt;

endmodule

// File: rvs_mem_if.sv
module rvs_mem_if (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_start,
   input  rvs_pkg::dec_t     i_dec,
   input  logic [31:0]       i_adr,
   input  logic [31:0]       i_wdata,
   output rvs_pkg::bus_req_t o_dbus,
   input  logic              i_dbus_ack,
   input  logic [31:0]       i_rdt,
   output logic              o_done,
   output logic [31:0]       o_rd
);

   logic        cyc_q;
   logic [31:0] adr_q;
   logic [31:0] dat_q;
   logic [3:0]  sel_q;
   logic        we_q;
   logic [1:0]  lane_q;
   logic [7:0]  byte_val;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cyc_q <= 1'b0;
      end else if (i_start) begin
         cyc_q <= 1'b1;
      end else if (i_dbus_ack) begin
         cyc_q <= 1'b0;
      end
   end

   // Request payload, held stable until ack
   always_ff @(posedge clk) begin
      if (i_start) begin
         adr_q  <= {i_adr[31:2], 2'b00};
         dat_q  <= i_dec.mem_byte ? {4{i_wdata[7:0]}} : i_wdata;
         sel_q  <= i_dec.mem_byte ? 4'b0001 << i_adr[1:0] : 4'hf;
         we_q   <= i_dec.is_store;
         lane_q <= i_adr[1:0];
      end
   end

   always_comb begin
      o_dbus.adr = adr_q;
      o_dbus.dat = dat_q;
      o_dbus.sel = sel_q;
      o_dbus.we  = we_q;
      o_dbus.cyc = cyc_q;
   end

   assign o_done   = cyc_q & i_dbus_ack;
   assign byte_val = i_rdt[{lane_q, 3'b000} +: 8];
   assign o_rd     = i_dec.mem_byte ?
                     {{24{~i_dec.mem_unsigned & byte_val[7]}}, byte_val} : i_rdt;

endmodule

// File: rvs_ctrl.sv
module rvs_ctrl #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic              clk,
   input  logic              i_rst_n,
   output rvs_pkg::bus_req_t o_ibus,
   input  logic              i_ibus_ack,
   input  logic [31:0]       i_rdt,
   output rvs_pkg::dec_t     o_dec,
   output logic [31:0]       o_imm,
   output logic [31:0]       o_alu_a,
   output logic [31:0]       o_alu_b,
   input  logic [31:0]       i_alu_result,
   input  logic              i_alu_eq,
   output logic              o_mem_start,
   input  logic              i_mem_done,
   input  logic [31:0]       i_mem_rd,
   output logic              o_rf_wen,
   output logic [4:0]        o_rf_waddr,
   output logic [31:0]       o_rf_wdata,
   output logic [4:0]        o_rf_raddr1,
   output logic [4:0]        o_rf_raddr2,
   input  logic [31:0]       i_rf_rdata1,
   input  logic [31:0]       i_rf_rdata2
);

   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      MEM
   } state_t;

   state_t          state;
   rvs_pkg::instr_t ir;
   logic [31:0]     pc;
   logic [31:0]     pc_plus4;
   logic [31:0]     pc_next;
   logic            taken;
   logic            mem_op;

   rvs_decode u_decode (
      .i_instr (ir),
      .o_dec   (o_dec),
      .o_imm   (o_imm)
   );

   assign mem_op   = o_dec.is_load | o_dec.is_store;
   assign pc_plus4 = pc + 32'd4;
   assign taken    = o_dec.is_jal | (o_dec.is_branch & (i_alu_eq != o_dec.branch_ne));
   assign pc_next  = taken ? pc + o_imm : pc_plus4;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= FETCH;
         pc    <= RESET_PC;
      end else begin
         case (state)
            FETCH: if (i_ibus_ack) state <= EXEC;
            EXEC: begin
               pc    <= pc_next;
               state <= mem_op ? MEM : FETCH;
            end
            MEM: if (i_mem_done) state <= FETCH;
            default: state <= FETCH;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == FETCH && i_ibus_ack) begin
         ir <= i_rdt;
      end
   end

   // No fetch request while reset is held
   always_comb begin
      o_ibus.adr = pc;
      o_ibus.dat = '0;
      o_ibus.sel = 4'hf;
      o_ibus.we  = 1'b0;
      o_ibus.cyc = i_rst_n & (state == FETCH);
   end

   assign o_alu_a     = i_rf_rdata1;
   assign o_alu_b     = o_dec.use_imm ? o_imm : i_rf_rdata2;
   assign o_mem_start = (state == EXEC) & mem_op;

   assign o_rf_raddr1 = o_dec.rs1;
   assign o_rf_raddr2 = o_dec.rs2;
   assign o_rf_waddr  = o_dec.rd;

   // Loads write in the data ack cycle, everything else in EXEC
   assign o_rf_wen = ((state == EXEC) & o_dec.rd_wen & ~o_dec.is_load) |
                     ((state == MEM) & o_dec.is_load & i_mem_done);

   always_comb begin
      case (o_dec.wb_src)
         rvs_pkg::WB_ALU: o_rf_wdata = i_alu_result;
         rvs_pkg::WB_MEM: o_rf_wdata = i_mem_rd;
         rvs_pkg::WB_PC4: o_rf_wdata = pc_plus4;
         rvs_pkg::WB_IMM: o_rf_wdata = o_imm;
         default:         o_rf_wdata = i_alu_result;
      endcase
   end

endmodule

// File: rvs_alu.sv
module rvs_alu (
   input  rvs_pkg::alu_op_t i_op,
   input  logic [31:0]      i_a,
   input  logic [31:0]      i_b,
   output logic [31:0]      o_result,
   output logic             o_eq
);

   logic [31:0] sum;
   logic [31:0] diff;
   logic        lt;

   assign sum  = i_a + i_b;
   assign diff = i_a - i_b;
   assign lt   = $signed(i_a) < $signed(i_b);

   // Branch compare works on rs1 and rs2 directly
   assign o_eq = i_a == i_b;

   always_comb begin
      case (i_op)
         rvs_pkg::ALU_ADD: o_result = sum;
         rvs_pkg::ALU_SUB: o_result = diff;
         rvs_pkg::ALU_AND: o_result = i_a & i_b;
         rvs_pkg::ALU_OR:  o_result = i_a | i_b;
         rvs_pkg::ALU_XOR: o_result = i_a ^ i_b;
         rvs_pkg::ALU_SLT: o_result = {31'h0, lt};
         default:          o_result = sum;
      endcase
   end

endmodule

// File: rvs_regfile.sv
module rvs_regfile (
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic        i_wen,
   input  logic [4:0]  i_waddr,
   input  logic [31:0] i_wdata,
   input  logic [4:0]  i_raddr1,
   input  logic [4:0]  i_raddr2,
   output logic [31:0] o_rdata1,
   output logic [31:0] o_rdata2
);

   // x0 has no storage
   logic [31:0] regs [1:31];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wen && i_waddr != 5'd0) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   assign o_rdata1 = (i_raddr1 == 5'd0) ? 32'h0 : regs[i_raddr1];
   assign o_rdata2 = (i_raddr2 == 5'd0) ? 32'h0 : regs[i_raddr2];

endmodule

// File: rvs_decode.sv
module rvs_decode (
   input  rvs_pkg::instr_t i_instr,
   output rvs_pkg::dec_t   o_dec,
   output logic [31:0]     o_imm
);

   logic [6:0]       opcode;
   logic [2:0]       funct3;
   rvs_pkg::alu_op_t f3_op;
   logic             f3_ok;
   logic             ld_ok;
   logic             st_ok;
   logic             br_ok;

   assign opcode = i_instr.r.opcode;
   assign funct3 = i_instr.r.funct3;

   assign ld_ok = funct3 == rvs_pkg::F3_LB || funct3 == rvs_pkg::F3_LW ||
                  funct3 == rvs_pkg::F3_LBU;
   assign st_ok = funct3 == rvs_pkg::F3_SB || funct3 == rvs_pkg::F3_SW;
   assign br_ok = funct3 == rvs_pkg::F3_BEQ || funct3 == rvs_pkg::F3_BNE;

   // ALU operation shared by OP and OP_IMM
   always_comb begin
      f3_ok = 1'b1;
      case (funct3)
         rvs_pkg::F3_ADD: f3_op = rvs_pkg::ALU_ADD;
         rvs_pkg::F3_SLT: f3_op = rvs_pkg::ALU_SLT;
         rvs_pkg::F3_XOR: f3_op = rvs_pkg::ALU_XOR;
         rvs_pkg::F3_OR:  f3_op = rvs_pkg::ALU_OR;
         rvs_pkg::F3_AND: f3_op = rvs_pkg::ALU_AND;
         default: begin
            f3_op = rvs_pkg::ALU_ADD;
            f3_ok = 1'b0;
         end
      endcase
   end

   always_comb begin
      o_dec        = '0;
      o_dec.rd     = i_instr.r.rd;
      o_dec.rs1    = i_instr.r.rs1;
      o_dec.rs2    = i_instr.r.rs2;
      o_dec.alu_op = rvs_pkg::ALU_ADD;
      o_dec.wb_src = rvs_pkg::WB_ALU;
      o_imm        = '0;
      case (opcode)
         rvs_pkg::OPC_OP: begin
            if (funct3 == rvs_pkg::F3_ADD && i_instr.r.funct7 == rvs_pkg::F7_SUB) begin
               o_dec.alu_op = rvs_pkg::ALU_SUB;
            end else begin
               o_dec.alu_op = f3_op;
            end
            o_dec.rd_wen = f3_ok;
         end
         rvs_pkg::OPC_OP_IMM: begin
            o_imm         = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
            o_dec.alu_op  = f3_op;
            o_dec.use_imm = 1'b1;
            o_dec.rd_wen  = f3_ok;
         end
         rvs_pkg::OPC_LUI: begin
            o_imm        = {i_instr.u.imm_31_12, 12'h000};
            o_dec.rd_wen = 1'b1;
            o_dec.wb_src = rvs_pkg::WB_IMM;
         end
         rvs_pkg::OPC_LOAD: begin
            o_imm              = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
            o_dec.use_imm      = 1'b1;
            o_dec.is_load      = ld_ok;
            o_dec.rd_wen       = ld_ok;
            o_dec.wb_src       = rvs_pkg::WB_MEM;
            o_dec.mem_byte     = funct3 != rvs_pkg::F3_LW;
            o_dec.mem_unsigned = funct3 == rvs_pkg::F3_LBU;
         end
         rvs_pkg::OPC_STORE: begin
            o_imm          = {{20{i_instr.s.imm_11_5[6]}}, i_instr.s.imm_11_5,
                              i_instr.s.imm_4_0};
            o_dec.use_imm  = 1'b1;
            o_dec.is_store = st_ok;
            o_dec.mem_byte = funct3 == rvs_pkg::F3_SB;
         end
         rvs_pkg::OPC_BRANCH: begin
            o_imm           = {{19{i_instr.b.imm_12}}, i_instr.b.imm_12, i_instr.b.imm_11,
                               i_instr.b.imm_10_5, i_instr.b.imm_4_1, 1'b0};
            o_dec.is_branch = br_ok;
            o_dec.branch_ne = funct3 == rvs_pkg::F3_BNE;
         end
         rvs_pkg::OPC_JAL: begin
            o_imm        = {{11{i_instr.j.imm_20}}, i_instr.j.imm_20, i_instr.j.imm_19_12,
                            i_instr.j.imm_11, i_instr.j.imm_10_1, 1'b0};
            o_dec.is_jal = 1'b1;
            o_dec.rd_wen = 1'b1;
            o_dec.wb_src = rvs_pkg::WB_PC4;
         end
         default: begin
            // Unknown opcode falls through as a no-op
            o_dec.rd_wen = 1'b0;
         end
      endcase
   end

endmodule

// File: rvs_pkg.sv
package rvs_pkg;

   // Instruction formats, fields listed from bit 31 down
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      u_fmt_t u;
      j_fmt_t j;
   } instr_t;

   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
      logic        cyc;
   } bus_req_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT
   } alu_op_t;

   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_PC4,
      WB_IMM
   } wb_src_t;

   typedef struct packed {
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      alu_op_t    alu_op;
      logic       use_imm;
      logic       rd_wen;
      logic       is_load;
      logic       is_store;
      logic       is_branch;
      logic       branch_ne;
      logic       is_jal;
      logic       mem_byte;
      logic       mem_unsigned;
      wb_src_t    wb_src;
   } dec_t;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_SLT = 3'b010;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_LB  = 3'b000;
   localparam logic [2:0] F3_LW  = 3'b010;
   localparam logic [2:0] F3_LBU = 3'b100;
   localparam logic [2:0] F3_SB  = 3'b000;
   localparam logic [2:0] F3_SW  = 3'b010;
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;

   localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage
